// File: rtl/rx_pkg.sv
////////////////////
// rx_pkg
// sample widths, sample-set layout, register map and reset values
// shared by the dual-radio receive path
////////////////////
`default_nettype none

package rx_pkg;

  // one I or Q sample from the radio
  localparam int samp_w = 12;

  typedef logic signed [samp_w-1:0] samp_t;

  typedef struct packed {
    samp_t i;
    samp_t q;
  } chan_t;

  // ch0/ch1 from radio a, ch2/ch3 from radio b
  typedef struct packed {
    chan_t ch0;
    chan_t ch1;
    chan_t ch2;
    chan_t ch3;
  } sample_set_t;

  // |i| + |q|, one bit wider than a sample
  typedef logic [samp_w:0] mag_t;

  // wishbone word addresses
  typedef enum logic [1:0] {
    REG_CTRL    = 2'd0,
    REG_THRESH  = 2'd1,
    REG_PKT_LEN = 2'd2,
    REG_STATUS  = 2'd3
  } reg_addr_e;

  // ctrl bit positions
  localparam int CTRL_ENABLE_A      = 0;
  localparam int CTRL_ENABLE_B      = 1;
  localparam int CTRL_GATE_EN       = 2;
  localparam int CTRL_RADIO_RESET_A = 3;
  localparam int CTRL_RADIO_RESET_B = 4;
  localparam int CTRL_W             = 5;

  localparam logic [CTRL_W-1:0] CTRL_RESET    = '0;
  localparam logic [7:0]        PKT_LEN_RESET = 8'd4;

endpackage

`default_nettype wire

// File: rtl/rx_sample_if.sv
////////////////////
// rx_sample_if
// one radio's deframed two-channel sample pair
////////////////////
`default_nettype none

interface rx_sample_if;

  // single-cycle strobe, ch0 and ch1 valid with it
  logic          valid;
  rx_pkg::chan_t ch0;
  rx_pkg::chan_t ch1;

  modport source (
    output valid,
    output ch0,
    output ch1
  );

  modport sink (
    input valid,
    input ch0,
    input ch1
  );

endinterface

`default_nettype wire

// File: rtl/cmos_rx_deframe.sv
////////////////////
// cmos_rx_deframe
// splits one radio's framed cmos words into a channel pair:
// frame high carries ch0, the following frame low carries ch1
////////////////////
`default_nettype none

module cmos_rx_deframe (
  input  logic          clk,
  input  logic          rst,
  input  logic          enable,
  input  logic          rx_frame_in,
  input  rx_pkg::samp_t rx_data_p0,
  input  rx_pkg::samp_t rx_data_p1,
  rx_sample_if.source   smp
);

  // set after a frame-high word, waiting for its partner
  logic          phase;
  logic          valid_q;
  rx_pkg::chan_t hold_ch0;
  rx_pkg::chan_t ch0_q;
  rx_pkg::chan_t ch1_q;
  logic          pair_done;

  // frame-low word that closes a pair
  assign pair_done = enable && !rx_frame_in && phase;

  ////////////////////
  // frame tracking
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      phase   <= 1'b0;
      valid_q <= 1'b0;
    end else if (!enable) begin
      phase   <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= pair_done;
      if (rx_frame_in) begin
        phase <= 1'b1;
      end else begin
        // lone frame-low words fall through here
        phase <= 1'b0;
      end
    end
  end

  ////////////////////
  // sample capture
  ////////////////////
  always_ff @(posedge clk) begin
    if (enable && rx_frame_in) begin
      hold_ch0.i <= rx_data_p0;
      hold_ch0.q <= rx_data_p1;
    end
    if (pair_done) begin
      ch0_q   <= hold_ch0;
      ch1_q.i <= rx_data_p0;
      ch1_q.q <= rx_data_p1;
    end
  end

  assign smp.valid = valid_q;
  assign smp.ch0   = ch0_q;
  assign smp.ch1   = ch1_q;

  // a pair needs two words, so valid is never back to back
  a_valid_spacing : assert property (
    @(posedge clk) disable iff (rst)
    smp.valid |=> !smp.valid
  );

endmodule

`default_nettype wire

// File: rtl/samp_energy_gate.sv
////////////////////
// samp_energy_gate
// joins radio a and b pairs into one four-channel set and
// drops quiet sets, keeping a pad tail after each loud one
////////////////////
`default_nettype none

module samp_energy_gate #(
  parameter int NUM_PAD_SAMPS = 7
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                gate_en,
  input  rx_pkg::mag_t        threshold,
  rx_sample_if.sink           rad_a,
  rx_sample_if.sink           rad_b,
  output logic                set_valid,
  output rx_pkg::sample_set_t set,
  output logic                misalign_evt
);

  localparam int PAD_W = (NUM_PAD_SAMPS > 0) ? $clog2(NUM_PAD_SAMPS + 1) : 1;

  logic             aligned;
  logic             loud;
  logic             pass;
  logic [PAD_W-1:0] pad_cnt;

  // |i| + |q| of one channel
  function automatic rx_pkg::mag_t chan_mag(input rx_pkg::chan_t c);
    logic signed [rx_pkg::samp_w:0] ei;
    logic signed [rx_pkg::samp_w:0] eq;
    ei = c.i;
    eq = c.q;
    if (ei < 0) ei = -ei;
    if (eq < 0) eq = -eq;
    return rx_pkg::mag_t'(ei) + rx_pkg::mag_t'(eq);
  endfunction

  ////////////////////
  // gate decision
  ////////////////////
  always_comb begin
    aligned = rad_a.valid && rad_b.valid;
    loud    = (chan_mag(rad_a.ch0) >= threshold) ||
              (chan_mag(rad_a.ch1) >= threshold) ||
              (chan_mag(rad_b.ch0) >= threshold) ||
              (chan_mag(rad_b.ch1) >= threshold);
    pass    = aligned && (!gate_en || loud || (pad_cnt != '0));
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      set_valid    <= 1'b0;
      misalign_evt <= 1'b0;
      pad_cnt      <= '0;
    end else begin
      set_valid    <= pass;
      // one radio delivered without the other
      misalign_evt <= rad_a.valid ^ rad_b.valid;
      if (!gate_en) begin
        pad_cnt <= '0;
      end else if (aligned) begin
        if (loud) begin
          pad_cnt <= PAD_W'(NUM_PAD_SAMPS);
        end else if (pad_cnt != '0) begin
          pad_cnt <= pad_cnt - 1'b1;
        end
      end
    end
  end

  // set payload
  always_ff @(posedge clk) begin
    if (pass) begin
      set.ch0 <= rad_a.ch0;
      set.ch1 <= rad_a.ch1;
      set.ch2 <= rad_b.ch0;
      set.ch3 <= rad_b.ch1;
    end
  end

  // output sets only come from pairs both deframers delivered together
  a_set_from_aligned : assert property (
    @(posedge clk) disable iff (rst)
    set_valid |-> $past(rad_a.valid && rad_b.valid)
  );

endmodule

`default_nettype wire

// File: rtl/axis_sample_packer.sv
////////////////////
// axis_sample_packer
// buffers sample sets and sends each as two 64-bit beats,
// tlast closing every pkt_len sets
////////////////////
`default_nettype none

module axis_sample_packer #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                set_valid,
  input  rx_pkg::sample_set_t set,
  input  logic [7:0]          pkt_len,
  output logic                m_axis_tvalid,
  input  logic                m_axis_tready,
  output logic                m_axis_tlast,
  output logic [63:0]         m_axis_tdata,
  output logic                ovf_evt
);

  localparam int ADDR_W = $clog2(FIFO_DEPTH);

  rx_pkg::sample_set_t mem [FIFO_DEPTH];
  logic [ADDR_W:0]     wr_ptr;
  logic [ADDR_W:0]     rd_ptr;
  logic                full;
  logic                empty;
  logic                beat;
  logic [7:0]          set_cnt;
  logic [7:0]          eff_len;
  logic [8:0]          next_cnt;
  logic                xfer;
  rx_pkg::sample_set_t head;

  // sign-extend one sample into a 16-bit lane
  function automatic logic [15:0] lane(input rx_pkg::samp_t s);
    return {{(16 - rx_pkg::samp_w){s[rx_pkg::samp_w-1]}}, s};
  endfunction

  // lower channel in the low half
  function automatic logic [63:0] pack(input rx_pkg::chan_t lo, input rx_pkg::chan_t hi);
    return {lane(hi.q), lane(hi.i), lane(lo.q), lane(lo.i)};
  endfunction

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                 (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

  ////////////////////
  // fifo write side
  ////////////////////
  always_ff @(posedge clk) begin
    if (set_valid && !full) begin
      mem[wr_ptr[ADDR_W-1:0]] <= set;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr  <= '0;
      ovf_evt <= 1'b0;
    end else begin
      ovf_evt <= set_valid && full;
      if (set_valid && !full) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  ////////////////////
  // stream side
  ////////////////////
  assign head     = mem[rd_ptr[ADDR_W-1:0]];
  assign xfer     = m_axis_tvalid && m_axis_tready;
  assign eff_len  = (pkt_len == 8'd0) ? 8'd1 : pkt_len;
  assign next_cnt = {1'b0, set_cnt} + 9'd1;

  assign m_axis_tvalid = !empty;
  assign m_axis_tdata  = beat ? pack(head.ch2, head.ch3) : pack(head.ch0, head.ch1);
  // >= also closes a packet cleanly when pkt_len shrinks mid-packet
  assign m_axis_tlast  = beat && (next_cnt >= {1'b0, eff_len});

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr  <= '0;
      beat    <= 1'b0;
      set_cnt <= '0;
    end else if (xfer) begin
      beat <= !beat;
      if (beat) begin
        rd_ptr  <= rd_ptr + 1'b1;
        set_cnt <= m_axis_tlast ? 8'd0 : next_cnt[7:0];
      end
    end
  end

  // held beat must not change under back-pressure
  a_tdata_stable : assert property (
    @(posedge clk) disable iff (rst)
    (m_axis_tvalid && !m_axis_tready) |=> (m_axis_tvalid && $stable(m_axis_tdata))
  );

endmodule

`default_nettype wire

// File: rtl/rx_ctrl_regs.sv
////////////////////
// rx_ctrl_regs
// wishbone classic register block: radio enables and resets,
// gate control, packet length and sticky status flags
////////////////////
`default_nettype none

module rx_ctrl_regs #(
  parameter int DATA_PASS_VALUE = 20
) (
  input  logic         clk,
  input  logic         rst,
  input  logic         wb_cyc,
  input  logic         wb_stb,
  input  logic         wb_we,
  input  logic [1:0]   wb_adr,
  input  logic [31:0]  wb_dat_w,
  output logic [31:0]  wb_dat_r,
  output logic         wb_ack,
  output logic         enable_a,
  output logic         enable_b,
  output logic         gate_en,
  output rx_pkg::mag_t threshold,
  output logic [7:0]   pkt_len,
  output logic         a_resetb,
  output logic         b_resetb,
  input  logic         ovf_evt,
  input  logic         misalign_evt
);

  logic [rx_pkg::CTRL_W-1:0] ctrl_q;
  logic                      ovf_flag;
  logic                      misalign_flag;
  logic                      req;
  logic                      wr;
  rx_pkg::reg_addr_e         addr;

  // new request, not yet acked
  assign req  = wb_cyc && wb_stb && !wb_ack;
  assign wr   = req && wb_we;
  assign addr = rx_pkg::reg_addr_e'(wb_adr);

  ////////////////////
  // register writes
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack        <= 1'b0;
      ctrl_q        <= rx_pkg::CTRL_RESET;
      threshold     <= rx_pkg::mag_t'(DATA_PASS_VALUE);
      pkt_len       <= rx_pkg::PKT_LEN_RESET;
      ovf_flag      <= 1'b0;
      misalign_flag <= 1'b0;
    end else begin
      wb_ack <= req;
      if (wr && addr == rx_pkg::REG_CTRL) begin
        ctrl_q <= wb_dat_w[rx_pkg::CTRL_W-1:0];
      end
      if (wr && addr == rx_pkg::REG_THRESH) begin
        threshold <= wb_dat_w[rx_pkg::samp_w:0];
      end
      if (wr && addr == rx_pkg::REG_PKT_LEN) begin
        pkt_len <= wb_dat_w[7:0];
      end
      // write 1 clears, a new event in the same cycle wins
      if (wr && addr == rx_pkg::REG_STATUS) begin
        ovf_flag      <= (ovf_flag & ~wb_dat_w[0]) | ovf_evt;
        misalign_flag <= (misalign_flag & ~wb_dat_w[1]) | misalign_evt;
      end else begin
        ovf_flag      <= ovf_flag | ovf_evt;
        misalign_flag <= misalign_flag | misalign_evt;
      end
    end
  end

  // read data lines up with ack
  always_ff @(posedge clk) begin
    if (req) begin
      case (addr)
        rx_pkg::REG_CTRL:    wb_dat_r <= {{(32 - rx_pkg::CTRL_W){1'b0}}, ctrl_q};
        rx_pkg::REG_THRESH:  wb_dat_r <= {{(31 - rx_pkg::samp_w){1'b0}}, threshold};
        rx_pkg::REG_PKT_LEN: wb_dat_r <= {24'd0, pkt_len};
        rx_pkg::REG_STATUS:  wb_dat_r <= {30'd0, misalign_flag, ovf_flag};
        default:             wb_dat_r <= 32'd0;
      endcase
    end
  end

  assign enable_a = ctrl_q[rx_pkg::CTRL_ENABLE_A];
  assign enable_b = ctrl_q[rx_pkg::CTRL_ENABLE_B];
  assign gate_en  = ctrl_q[rx_pkg::CTRL_GATE_EN];
  assign a_resetb = !ctrl_q[rx_pkg::CTRL_RADIO_RESET_A];
  assign b_resetb = !ctrl_q[rx_pkg::CTRL_RADIO_RESET_B];

  a_ack_pulse : assert property (
    @(posedge clk) disable iff (rst)
    wb_ack |=> !wb_ack
  );

endmodule

`default_nettype wire

// File: rtl/ad9361_dual_rx.sv
////////////////////
// ad9361_dual_rx
// receive subsystem for two cmos-port radios on one data clock:
// deframe, align and gate, then pack onto 64-bit axi-stream
////////////////////
`default_nettype none

module ad9361_dual_rx #(
  parameter int NUM_PAD_SAMPS   = 7,
  parameter int DATA_PASS_VALUE = 20,
  parameter int FIFO_DEPTH      = 8
) (
  input  logic          clk,
  input  logic          rst,

  // radio a
  input  logic          a_rx_frame_in,
  input  rx_pkg::samp_t a_rx_data_p0,
  input  rx_pkg::samp_t a_rx_data_p1,
  output logic          a_enable,
  output logic          a_resetb,

  // radio b
  input  logic          b_rx_frame_in,
  input  rx_pkg::samp_t b_rx_data_p0,
  input  rx_pkg::samp_t b_rx_data_p1,
  output logic          b_enable,
  output logic          b_resetb,

  // wishbone slave
  input  logic          wb_cyc,
  input  logic          wb_stb,
  input  logic          wb_we,
  input  logic [1:0]    wb_adr,
  input  logic [31:0]   wb_dat_w,
  output logic [31:0]   wb_dat_r,
  output logic          wb_ack,

  // axi-stream master
  output logic          m_axis_tvalid,
  input  logic          m_axis_tready,
  output logic          m_axis_tlast,
  output logic [63:0]   m_axis_tdata
);

  rx_sample_if smp_a ();
  rx_sample_if smp_b ();

  logic                gate_en;
  rx_pkg::mag_t        threshold;
  logic [7:0]          pkt_len;
  logic                set_valid;
  rx_pkg::sample_set_t set;
  logic                ovf_evt;
  logic                misalign_evt;

  ////////////////////
  // deframers
  ////////////////////
  cmos_rx_deframe u_deframe_a (
    .clk         (clk),
    .rst         (rst),
    .enable      (a_enable),
    .rx_frame_in (a_rx_frame_in),
    .rx_data_p0  (a_rx_data_p0),
    .rx_data_p1  (a_rx_data_p1),
    .smp         (smp_a.source)
  );

  cmos_rx_deframe u_deframe_b (
    .clk         (clk),
    .rst         (rst),
    .enable      (b_enable),
    .rx_frame_in (b_rx_frame_in),
    .rx_data_p0  (b_rx_data_p0),
    .rx_data_p1  (b_rx_data_p1),
    .smp         (smp_b.source)
  );

  ////////////////////
  // align, gate, pack
  ////////////////////
  samp_energy_gate #(
    .NUM_PAD_SAMPS (NUM_PAD_SAMPS)
  ) u_gate (
    .clk          (clk),
    .rst          (rst),
    .gate_en      (gate_en),
    .threshold    (threshold),
    .rad_a        (smp_a.sink),
    .rad_b        (smp_b.sink),
    .set_valid    (set_valid),
    .set          (set),
    .misalign_evt (misalign_evt)
  );

  axis_sample_packer #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_packer (
    .clk           (clk),
    .rst           (rst),
    .set_valid     (set_valid),
    .set           (set),
    .pkt_len       (pkt_len),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tdata  (m_axis_tdata),
    .ovf_evt       (ovf_evt)
  );

  // control and status
  rx_ctrl_regs #(
    .DATA_PASS_VALUE (DATA_PASS_VALUE)
  ) u_regs (
    .clk          (clk),
    .rst          (rst),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_w     (wb_dat_w),
    .wb_dat_r     (wb_dat_r),
    .wb_ack       (wb_ack),
    .enable_a     (a_enable),
    .enable_b     (b_enable),
    .gate_en      (gate_en),
    .threshold    (threshold),
    .pkt_len      (pkt_len),
    .a_resetb     (a_resetb),
    .b_resetb     (b_resetb),
    .ovf_evt      (ovf_evt),
    .misalign_evt (misalign_evt)
  );

endmodule

`default_nettype wire

// File: sim/tb_ad9361_dual_rx.sv
////////////////////
// tb_ad9361_dual_rx
// directed testbench for the dual-radio receive path: radio
// drivers, wishbone access, stream monitor and watchdog
////////////////////
`default_nettype none

module tb_ad9361_dual_rx;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_PAD      = 7;
  localparam int PASS_VALUE   = 20;
  localparam int DEPTH        = 8;
  // rough cycle budget per test, plus slack
  localparam int TEST_CYCLES  = 150 + 250 + 350 + 250 + 150;
  localparam int WATCHDOG_NS  = (TEST_CYCLES + 400) * 10;

  logic          clk = 1'b0;
  logic          rst;
  logic          a_rx_frame_in, b_rx_frame_in;
  rx_pkg::samp_t a_rx_data_p0, a_rx_data_p1, b_rx_data_p0, b_rx_data_p1;
  logic          a_enable, b_enable, a_resetb, b_resetb;
  logic          wb_cyc, wb_stb, wb_we, wb_ack;
  logic [1:0]    wb_adr;
  logic [31:0]   wb_dat_w, wb_dat_r;
  logic          m_axis_tvalid, m_axis_tready, m_axis_tlast;
  logic [63:0]   m_axis_tdata;

  // reference model state
  rx_pkg::sample_set_t ref_q[$];
  logic [31:0]         lfsr = 32'd92373;
  int                  mismatch_cnt = 0;
  int                  fault_cnt = 0;
  int                  exp_len = 4;
  int                  pkt_cnt = 0;
  int                  pad_left = 0;
  int                  beat_total = 0;
  logic                gate_on = 1'b0;
  rx_pkg::mag_t        exp_thresh = PASS_VALUE;

  // monitor state
  logic                beat_odd = 1'b0;
  logic [63:0]         first_beat;
  rx_pkg::sample_set_t got_set;
  rx_pkg::sample_set_t exp_set;
  logic                exp_last;

  ad9361_dual_rx #(
    .NUM_PAD_SAMPS   (NUM_PAD),
    .DATA_PASS_VALUE (PASS_VALUE),
    .FIFO_DEPTH      (DEPTH)
  ) UUT (.*);

  always #5 clk = ~clk;

  ////////////////////
  // compare tasks
  ////////////////////
  task automatic check_set(input string name, input rx_pkg::sample_set_t got,
                           input rx_pkg::sample_set_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_reg(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  ////////////////////
  // stimulus helpers
  ////////////////////
  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic lfsr_step();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) v = {v[30:0], lfsr_step()};
    return v;
  endfunction

  // every sample sign-extended from a random field of the given width
  function automatic rx_pkg::sample_set_t random_set(input int bits);
    logic [rx_pkg::samp_w-1:0] s [8];
    int                        sv;
    for (int k = 0; k < 8; k++) begin
      sv   = int'(rand_bits(bits) << (32 - bits)) >>> (32 - bits);
      s[k] = sv[rx_pkg::samp_w-1:0];
    end
    return {s[0], s[1], s[2], s[3], s[4], s[5], s[6], s[7]};
  endfunction

  function automatic rx_pkg::mag_t chan_level(input rx_pkg::chan_t c);
    int ai;
    int aq;
    ai = (c.i < 0) ? -int'(c.i) : int'(c.i);
    aq = (c.q < 0) ? -int'(c.q) : int'(c.q);
    return rx_pkg::mag_t'(ai + aq);
  endfunction

  // expected gate decision for one aligned set
  function automatic logic predict_pass(input rx_pkg::sample_set_t s);
    logic loud;
    loud = (chan_level(s.ch0) >= exp_thresh) || (chan_level(s.ch1) >= exp_thresh) ||
           (chan_level(s.ch2) >= exp_thresh) || (chan_level(s.ch3) >= exp_thresh);
    if (!gate_on) return 1'b1;
    if (loud) begin
      pad_left = NUM_PAD;
      return 1'b1;
    end
    if (pad_left > 0) begin
      pad_left--;
      return 1'b1;
    end
    return 1'b0;
  endfunction

  // both radios frame the same set in the same cycles
  task automatic send_set(input rx_pkg::sample_set_t s, input logic keep);
    @(posedge clk);
    #1;
    a_rx_frame_in = 1'b1;
    b_rx_frame_in = 1'b1;
    a_rx_data_p0  = s.ch0.i;
    a_rx_data_p1  = s.ch0.q;
    b_rx_data_p0  = s.ch2.i;
    b_rx_data_p1  = s.ch2.q;
    @(posedge clk);
    #1;
    a_rx_frame_in = 1'b0;
    b_rx_frame_in = 1'b0;
    a_rx_data_p0  = s.ch1.i;
    a_rx_data_p1  = s.ch1.q;
    b_rx_data_p0  = s.ch3.i;
    b_rx_data_p1  = s.ch3.q;
    if (keep) ref_q.push_back(s);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic wait_drain();
    int cnt;
    cnt = 0;
    while (ref_q.size() != 0 && cnt < 200) begin
      @(posedge clk);
      cnt++;
    end
    if (ref_q.size() != 0) begin
      fault_cnt++;
      $display("error at %0t: %0d expected sets never left the stream", $time, ref_q.size());
      ref_q.delete();
    end
    idle_cycles(4);
  endtask

  ////////////////////
  // wishbone master
  ////////////////////
  task automatic wb_access(input logic we, input rx_pkg::reg_addr_e addr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    int cnt;
    @(posedge clk);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = addr;
    wb_dat_w = wdata;
    cnt      = 0;
    do begin
      @(negedge clk);
      cnt++;
    end while (!wb_ack && cnt < 16);
    if (!wb_ack) begin
      fault_cnt++;
      $display("error at %0t: no wishbone ack for address %0d", $time, addr);
    end
    rdata = wb_dat_r;
    @(posedge clk);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic reg_write(input rx_pkg::reg_addr_e addr, input logic [31:0] data);
    logic [31:0] unused;
    wb_access(1'b1, addr, data, unused);
  endtask

  task automatic reg_read_check(input rx_pkg::reg_addr_e addr, input logic [31:0] exp);
    logic [31:0] rdata;
    wb_access(1'b0, addr, 32'd0, rdata);
    check_reg({"wb_dat_r ", addr.name()}, rdata, exp);
  endtask

  ////////////////////
  // stream monitor
  ////////////////////
  function automatic rx_pkg::chan_t half_chan(input logic [31:0] h);
    rx_pkg::chan_t c;
    c.i = h[11:0];
    c.q = h[27:16];
    return c;
  endfunction

  function automatic logic lanes_extended(input logic [63:0] d);
    logic ok;
    ok = 1'b1;
    for (int k = 0; k < 4; k++) begin
      if (d[16*k+12 +: 4] != {4{d[16*k+11]}}) ok = 1'b0;
    end
    return ok;
  endfunction

  // sampled mid-cycle, where the handshake is settled
  always @(negedge clk) begin
    if (!rst && m_axis_tvalid && m_axis_tready) begin
      beat_total++;
      check_bit("m_axis_tdata sign extension", lanes_extended(m_axis_tdata), 1'b1);
      if (!beat_odd) begin
        first_beat = m_axis_tdata;
        check_bit("m_axis_tlast", m_axis_tlast, 1'b0);
        beat_odd = 1'b1;
      end else begin
        beat_odd    = 1'b0;
        got_set.ch0 = half_chan(first_beat[31:0]);
        got_set.ch1 = half_chan(first_beat[63:32]);
        got_set.ch2 = half_chan(m_axis_tdata[31:0]);
        got_set.ch3 = half_chan(m_axis_tdata[63:32]);
        if (ref_q.size() == 0) begin
          fault_cnt++;
          $display("error at %0t: stream sent a set that was not expected", $time);
        end else begin
          exp_set = ref_q.pop_front();
          check_set("m_axis_tdata set", got_set, exp_set);
          pkt_cnt++;
          exp_last = (pkt_cnt >= ((exp_len == 0) ? 1 : exp_len));
          if (exp_last) pkt_cnt = 0;
          check_bit("m_axis_tlast", m_axis_tlast, exp_last);
        end
      end
    end
  end

  ////////////////////
  // tests
  ////////////////////
  task automatic register_access();
    reg_read_check(rx_pkg::REG_CTRL, 32'd0);
    reg_read_check(rx_pkg::REG_THRESH, PASS_VALUE);
    reg_read_check(rx_pkg::REG_PKT_LEN, 32'd4);
    reg_read_check(rx_pkg::REG_STATUS, 32'd0);
    check_bit("a_resetb", a_resetb, 1'b1);
    check_bit("b_resetb", b_resetb, 1'b1);
    // unused upper bits read back as zero
    reg_write(rx_pkg::REG_CTRL, 32'hFFFF_FFFF);
    reg_read_check(rx_pkg::REG_CTRL, 32'h1F);
    check_bit("a_enable", a_enable, 1'b1);
    check_bit("b_enable", b_enable, 1'b1);
    check_bit("a_resetb", a_resetb, 1'b0);
    check_bit("b_resetb", b_resetb, 1'b0);
    reg_write(rx_pkg::REG_CTRL, 32'h10);
    check_bit("a_resetb", a_resetb, 1'b1);
    check_bit("b_resetb", b_resetb, 1'b0);
    reg_write(rx_pkg::REG_THRESH, 32'd100);
    reg_read_check(rx_pkg::REG_THRESH, 32'd100);
    reg_write(rx_pkg::REG_PKT_LEN, 32'd9);
    reg_read_check(rx_pkg::REG_PKT_LEN, 32'd9);
    reg_write(rx_pkg::REG_PKT_LEN, 32'd4);
    reg_write(rx_pkg::REG_CTRL, 32'h0);
    exp_thresh = 100;
  endtask

  task automatic bypass_stream();
    reg_write(rx_pkg::REG_CTRL, 32'h3);
    gate_on = 1'b0;
    exp_len = 4;
    repeat (8) send_set(random_set(12), 1'b1);
    wait_drain();
    reg_write(rx_pkg::REG_PKT_LEN, 32'd3);
    reg_read_check(rx_pkg::REG_PKT_LEN, 32'd3);
    exp_len = 3;
    repeat (6) send_set(random_set(12), 1'b1);
    wait_drain();
  endtask

  task automatic energy_gating();
    rx_pkg::sample_set_t s;
    reg_write(rx_pkg::REG_THRESH, 32'd200);
    exp_thresh = 200;
    reg_write(rx_pkg::REG_CTRL, 32'h7);
    gate_on  = 1'b1;
    pad_left = 0;
    for (int n = 0; n < 31; n++) begin
      s = random_set(4);
      // loud sets at 3, 16 and 20 with 20 inside the tail
      // each one reaches the threshold through another channel
      if (n == 3) begin
        s.ch1.i = '0;
        s.ch1.q = 12'sd200;
      end
      if (n == 16) begin
        s.ch2.i = -12'sd120;
        s.ch2.q = 12'sd80;
      end
      if (n == 20) begin
        s.ch3.i = 12'sd50;
        s.ch3.q = -12'sd150;
      end
      send_set(s, predict_pass(s));
    end
    wait_drain();
  endtask

  task automatic back_pressure();
    reg_write(rx_pkg::REG_CTRL, 32'h3);
    gate_on = 1'b0;
    @(posedge clk);
    #1;
    m_axis_tready = 1'b0;
    for (int n = 0; n < DEPTH + 3; n++) begin
      send_set(random_set(12), n < DEPTH);
    end
    idle_cycles(6);
    reg_read_check(rx_pkg::REG_STATUS, 32'h1);
    reg_write(rx_pkg::REG_STATUS, 32'h1);
    reg_read_check(rx_pkg::REG_STATUS, 32'h0);
    @(posedge clk);
    #1;
    m_axis_tready = 1'b1;
    wait_drain();
  endtask

  task automatic enable_alignment();
    int beats_before;
    beats_before = beat_total;
    reg_write(rx_pkg::REG_CTRL, 32'h1);
    check_bit("a_enable", a_enable, 1'b1);
    check_bit("b_enable", b_enable, 1'b0);
    repeat (4) send_set(random_set(12), 1'b0);
    idle_cycles(10);
    reg_read_check(rx_pkg::REG_STATUS, 32'h2);
    reg_write(rx_pkg::REG_STATUS, 32'h2);
    reg_write(rx_pkg::REG_CTRL, 32'h0);
    check_bit("a_enable", a_enable, 1'b0);
    check_bit("b_enable", b_enable, 1'b0);
    repeat (4) send_set(random_set(12), 1'b0);
    idle_cycles(10);
    reg_read_check(rx_pkg::REG_STATUS, 32'h0);
    if (beat_total != beats_before) begin
      fault_cnt++;
      $display("error at %0t: stream beats seen with a radio disabled", $time);
    end
  endtask

  ////////////////////
  // main sequence
  ////////////////////
  initial begin
    rst           = 1'b1;
    a_rx_frame_in = 1'b0;
    b_rx_frame_in = 1'b0;
    a_rx_data_p0  = '0;
    a_rx_data_p1  = '0;
    b_rx_data_p0  = '0;
    b_rx_data_p1  = '0;
    wb_cyc        = 1'b0;
    wb_stb        = 1'b0;
    wb_we         = 1'b0;
    wb_adr        = '0;
    wb_dat_w      = '0;
    m_axis_tready = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    check_bit("m_axis_tvalid", m_axis_tvalid, 1'b0);
    check_bit("a_enable", a_enable, 1'b0);
    check_bit("b_enable", b_enable, 1'b0);

    register_access();
    bypass_stream();
    energy_gating();
    back_pressure();
    enable_alignment();

    $display("finished with %0d mismatches and %0d other errors", mismatch_cnt, fault_cnt);
    if (mismatch_cnt == 0 && fault_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("error: run timed out after %0d ns", WATCHDOG_NS);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
rtl/rx_pkg.sv
rtl/rx_sample_if.sv
rtl/cmos_rx_deframe.sv
rtl/samp_energy_gate.sv
rtl/axis_sample_packer.sv
rtl/rx_ctrl_regs.sv
rtl/ad9361_dual_rx.sv
sim/tb_ad9361_dual_rx.sv

// File: Bender.yml
package:
  name: ad9361_dual_rx

sources:
  - files:
      - rtl/rx_pkg.sv
      - rtl/rx_sample_if.sv
      - rtl/cmos_rx_deframe.sv
      - rtl/samp_energy_gate.sv
      - rtl/axis_sample_packer.sv
      - rtl/rx_ctrl_regs.sv
      - rtl/ad9361_dual_rx.sv
  - target: simulation
    files:
      - sim/tb_ad9361_dual_rx.sv
